//--- logic/bpu_pkg.sv
package bpu_pkg;

    localparam int XLEN = 32;

    // bimodal counters, index pc[9:1]
    localparam int BIMODAL_ENTRIES = 512;
    localparam int BIMODAL_IDX_W   = 9;

    // direct-mapped btb, index pc[9:2], tag pc[31:10]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_TAG_W   = 22;

    // ras pointer counts 0..RAS_DEPTH entries
    localparam int RAS_DEPTH = 16;
    localparam int RAS_PTR_W = 5;

    localparam logic [1:0] CTR_RESET = 2'b01;  // weakly not taken
    localparam logic [1:0] CTR_MAX   = 2'b11;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // one instruction word seen through its three immediate layouts
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_u;

    // jalr x0, 0(ra) or jalr x0, 0(t0)
    function automatic logic is_return(input inst_u word);
        logic link_src;
        link_src = (word.i.rs1 == REG_RA) || (word.i.rs1 == REG_T0);
        return (word.i.opcode == OP_JALR) && (word.i.rd == 5'd0) && link_src
            && (word.i.imm12 == 12'd0);
    endfunction

endpackage

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import bpu_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_valid_i,
    input  logic [XLEN-1:0]          fetch_pc_i,
    input  logic [XLEN-1:0]          fetch_inst_i,
    output logic [BIMODAL_IDX_W-1:0] bm_index_o,
    output logic [BTB_IDX_W-1:0]     btb_index_o,
    output logic [BTB_TAG_W-1:0]     btb_tag_o,
    output logic                     s1_valid_o,
    output logic                     s1_cond_o,
    output logic                     s1_jal_o,
    output logic                     s1_jalr_o,
    output logic                     s1_ret_o,
    output logic [XLEN-1:0]          s1_static_target_o,
    output logic [XLEN-1:0]          s1_seq_pc_o
);

    inst_u           inst;
    logic            is_cond;
    logic            is_jal;
    logic            is_jalr;
    logic [XLEN-1:0] b_offset;
    logic [XLEN-1:0] j_offset;

    assign inst = fetch_inst_i;

    assign is_cond = (inst.b.opcode == OP_BRANCH);
    assign is_jal  = (inst.j.opcode == OP_JAL);
    assign is_jalr = (inst.i.opcode == OP_JALR);

    // sign-extended immediates, bit 0 always zero
    assign b_offset = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                       inst.b.imm4_1, 1'b0};
    assign j_offset = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                       inst.j.imm10_1, 1'b0};

    // table lookups go out unregistered, the tables register their own read
    assign bm_index_o  = fetch_pc_i[BIMODAL_IDX_W:1];
    assign btb_index_o = fetch_pc_i[BTB_IDX_W+1:2];
    assign btb_tag_o   = fetch_pc_i[XLEN-1:XLEN-BTB_TAG_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid_o <= 1'b0;
            s1_cond_o  <= 1'b0;
            s1_jal_o   <= 1'b0;
            s1_jalr_o  <= 1'b0;
            s1_ret_o   <= 1'b0;
        end else begin
            s1_valid_o <= fetch_valid_i;
            s1_cond_o  <= fetch_valid_i && is_cond;
            s1_jal_o   <= fetch_valid_i && is_jal;
            s1_jalr_o  <= fetch_valid_i && is_jalr;
            s1_ret_o   <= fetch_valid_i && is_return(inst);
        end
    end

    always_ff @(posedge clk) begin
        s1_static_target_o <= fetch_pc_i + (is_jal ? j_offset : b_offset);
        s1_seq_pc_o        <= fetch_pc_i + 32'd4;  // fall-through
    end

endmodule

//--- logic/bimodal_table.sv
`timescale 1ns/1ps

module bimodal_table import bpu_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [BIMODAL_IDX_W-1:0] rd_index_i,
    input  logic                     ex_valid_i,
    input  logic [XLEN-1:0]          ex_pc_i,
    input  logic                     ex_taken_i,
    output logic                     ctr_msb_o
);

    logic [1:0]               ctr_q [BIMODAL_ENTRIES];
    logic [BIMODAL_IDX_W-1:0] wr_index;
    logic [1:0]               wr_ctr;
    logic [1:0]               wr_ctr_next;

    assign wr_index = ex_pc_i[BIMODAL_IDX_W:1];
    assign wr_ctr   = ctr_q[wr_index];

    // saturating step
    always_comb begin
        wr_ctr_next = wr_ctr;
        if (ex_taken_i && (wr_ctr != CTR_MAX)) begin
            wr_ctr_next = wr_ctr + 2'd1;
        end else if (!ex_taken_i && (wr_ctr != 2'd0)) begin
            wr_ctr_next = wr_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
            ctr_msb_o <= 1'b0;
        end else begin
            ctr_msb_o <= ctr_q[rd_index_i][1];  // old value on a same-edge update
            if (ex_valid_i) begin
                ctr_q[wr_index] <= wr_ctr_next;
            end
        end
    end

endmodule

//--- logic/target_buffer.sv
`timescale 1ns/1ps

module target_buffer import bpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [BTB_IDX_W-1:0] rd_index_i,
    input  logic [BTB_TAG_W-1:0] rd_tag_i,
    input  logic                 ex_valid_i,
    input  logic [XLEN-1:0]      ex_pc_i,
    input  logic                 ex_taken_i,
    input  logic [XLEN-1:0]      ex_target_i,
    output logic                 hit_o,
    output logic [XLEN-1:0]      target_o
);

    logic                 valid_q  [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0] tag_q    [BTB_ENTRIES];
    logic [XLEN-1:0]      target_q [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] wr_index;
    logic [BTB_TAG_W-1:0] wr_tag;
    logic                 fill;

    assign wr_index = ex_pc_i[BTB_IDX_W+1:2];
    assign wr_tag   = ex_pc_i[XLEN-1:XLEN-BTB_TAG_W];
    assign fill     = ex_valid_i && ex_taken_i;  // only taken branches allocate

    // valid bits and the hit flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
            hit_o <= 1'b0;
        end else begin
            hit_o <= valid_q[rd_index_i] && (tag_q[rd_index_i] == rd_tag_i);
            if (fill) begin
                valid_q[wr_index] <= 1'b1;
            end
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        target_o <= target_q[rd_index_i];
        if (fill) begin
            tag_q[wr_index]    <= wr_tag;
            target_q[wr_index] <= ex_target_i;
        end
    end

endmodule

//--- logic/return_stack.sv
`timescale 1ns/1ps

module return_stack import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            ex_valid_i,
    input  logic            ex_taken_i,
    input  logic [XLEN-1:0] ex_inst_i,
    input  logic            ex_stall_i,
    input  logic            id_push_i,
    input  logic [XLEN-1:0] id_push_addr_i,
    output logic            top_valid_o,
    output logic [XLEN-1:0] top_addr_o
);

    inst_u                ex_word;
    logic [XLEN-1:0]      stack_q [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] sp_q;       // number of entries
    logic [RAS_PTR_W-1:0] sp_popped;
    logic [RAS_PTR_W-1:0] top_index;
    logic                 pop;
    logic                 push;

    assign ex_word = ex_inst_i;

    // resolved taken return pops, never below empty
    assign pop = ex_valid_i && ex_taken_i && !ex_stall_i && is_return(ex_word)
              && (sp_q != '0);

    // pop goes first, a push then lands in the freed slot
    assign sp_popped = sp_q - RAS_PTR_W'(pop);
    assign push      = id_push_i && !ex_stall_i && (sp_popped != RAS_PTR_W'(RAS_DEPTH));

    assign top_index = sp_q - 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q        <= '0;
            top_valid_o <= 1'b0;
        end else begin
            sp_q        <= sp_popped + RAS_PTR_W'(push);
            top_valid_o <= (sp_q != '0);
        end
    end

    always_ff @(posedge clk) begin
        top_addr_o <= stack_q[top_index[RAS_PTR_W-2:0]];  // don't care when empty
        if (push) begin
            stack_q[sp_popped[RAS_PTR_W-2:0]] <= id_push_addr_i;
        end
    end

endmodule

//--- logic/select_stage.sv
`timescale 1ns/1ps

module select_stage import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            s1_valid_i,
    input  logic            s1_cond_i,
    input  logic            s1_jal_i,
    input  logic            s1_jalr_i,
    input  logic            s1_ret_i,
    input  logic [XLEN-1:0] s1_static_target_i,
    input  logic [XLEN-1:0] s1_seq_pc_i,
    input  logic            ctr_msb_i,
    input  logic            btb_hit_i,
    input  logic [XLEN-1:0] btb_target_i,
    input  logic            ras_valid_i,
    input  logic [XLEN-1:0] ras_addr_i,
    output logic            pred_valid_o,
    output logic            pred_branch_o,
    output logic            pred_taken_o,
    output logic [XLEN-1:0] pred_target_o
);

    logic            is_branch;
    logic            taken;
    logic [XLEN-1:0] taken_target;

    assign is_branch = s1_cond_i || s1_jal_i || s1_jalr_i;

    always_comb begin
        taken        = 1'b0;
        taken_target = s1_seq_pc_i;
        if (s1_ret_i) begin
            taken        = ras_valid_i;  // empty stack falls through
            taken_target = ras_addr_i;
        end else if (s1_jal_i) begin
            taken        = 1'b1;
            taken_target = btb_hit_i ? btb_target_i : s1_static_target_i;
        end else if (s1_cond_i) begin
            taken        = ctr_msb_i;
            taken_target = btb_hit_i ? btb_target_i : s1_static_target_i;
        end else if (s1_jalr_i) begin
            // register target unknown here, only the btb can help
            taken        = ctr_msb_i;
            taken_target = btb_hit_i ? btb_target_i : s1_seq_pc_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid_o  <= 1'b0;
            pred_branch_o <= 1'b0;
            pred_taken_o  <= 1'b0;
        end else begin
            pred_valid_o  <= s1_valid_i;
            pred_branch_o <= s1_valid_i && is_branch;
            pred_taken_o  <= s1_valid_i && taken;
        end
    end

    always_ff @(posedge clk) begin
        pred_target_o <= taken ? taken_target : s1_seq_pc_i;
    end

endmodule

//--- logic/bpu_top.sv
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    // fetch
    input  logic            fetch_valid_i,
    input  logic [XLEN-1:0] fetch_pc_i,
    input  logic [XLEN-1:0] fetch_inst_i,
    // resolved branches from execute
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] ex_pc_i,
    input  logic            ex_taken_i,
    input  logic [XLEN-1:0] ex_target_i,
    input  logic [XLEN-1:0] ex_inst_i,
    input  logic            ex_stall_i,
    // call push from decode
    input  logic            id_push_i,
    input  logic [XLEN-1:0] id_push_addr_i,
    // prediction
    output logic            pred_valid_o,
    output logic            pred_branch_o,
    output logic            pred_taken_o,
    output logic [XLEN-1:0] pred_target_o
);

    logic [BIMODAL_IDX_W-1:0] bm_index;
    logic [BTB_IDX_W-1:0]     btb_index;
    logic [BTB_TAG_W-1:0]     btb_tag;

    // stage 1 fields
    logic            s1_valid;
    logic            s1_cond;
    logic            s1_jal;
    logic            s1_jalr;
    logic            s1_ret;
    logic [XLEN-1:0] s1_static_target;
    logic [XLEN-1:0] s1_seq_pc;

    // lookup results, aligned with stage 1
    logic            ctr_msb;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            ras_valid;
    logic [XLEN-1:0] ras_addr;

    decode_stage decode_i (
        .clk                (clk),
        .rst                (rst),
        .fetch_valid_i      (fetch_valid_i),
        .fetch_pc_i         (fetch_pc_i),
        .fetch_inst_i       (fetch_inst_i),
        .bm_index_o         (bm_index),
        .btb_index_o        (btb_index),
        .btb_tag_o          (btb_tag),
        .s1_valid_o         (s1_valid),
        .s1_cond_o          (s1_cond),
        .s1_jal_o           (s1_jal),
        .s1_jalr_o          (s1_jalr),
        .s1_ret_o           (s1_ret),
        .s1_static_target_o (s1_static_target),
        .s1_seq_pc_o        (s1_seq_pc)
    );

    bimodal_table bimodal_i (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (bm_index),
        .ex_valid_i (ex_valid_i),
        .ex_pc_i    (ex_pc_i),
        .ex_taken_i (ex_taken_i),
        .ctr_msb_o  (ctr_msb)
    );

    target_buffer btb_i (
        .clk         (clk),
        .rst         (rst),
        .rd_index_i  (btb_index),
        .rd_tag_i    (btb_tag),
        .ex_valid_i  (ex_valid_i),
        .ex_pc_i     (ex_pc_i),
        .ex_taken_i  (ex_taken_i),
        .ex_target_i (ex_target_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    return_stack ras_i (
        .clk            (clk),
        .rst            (rst),
        .ex_valid_i     (ex_valid_i),
        .ex_taken_i     (ex_taken_i),
        .ex_inst_i      (ex_inst_i),
        .ex_stall_i     (ex_stall_i),
        .id_push_i      (id_push_i),
        .id_push_addr_i (id_push_addr_i),
        .top_valid_o    (ras_valid),
        .top_addr_o     (ras_addr)
    );

    select_stage select_i (
        .clk                (clk),
        .rst                (rst),
        .s1_valid_i         (s1_valid),
        .s1_cond_i          (s1_cond),
        .s1_jal_i           (s1_jal),
        .s1_jalr_i          (s1_jalr),
        .s1_ret_i           (s1_ret),
        .s1_static_target_i (s1_static_target),
        .s1_seq_pc_i        (s1_seq_pc),
        .ctr_msb_i          (ctr_msb),
        .btb_hit_i          (btb_hit),
        .btb_target_i       (btb_target),
        .ras_valid_i        (ras_valid),
        .ras_addr_i         (ras_addr),
        .pred_valid_o       (pred_valid_o),
        .pred_branch_o      (pred_branch_o),
        .pred_taken_o       (pred_taken_o),
        .pred_target_o      (pred_target_o)
    );

endmodule

//--- testbench/tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu import bpu_pkg::*; ();

    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DELAY  = 10;
    localparam int    RESET_CYCLES = 5;
    localparam string STIM_FILE    = "testbench/bpu_stimulus.txt";

    // one line of the stimulus file
    typedef struct packed {
        logic            fetch_valid;
        logic [XLEN-1:0] fetch_pc;
        logic [XLEN-1:0] fetch_inst;
        logic            ex_valid;
        logic [XLEN-1:0] ex_pc;
        logic            ex_taken;
        logic [XLEN-1:0] ex_target;
        logic [XLEN-1:0] ex_inst;
        logic            ex_stall;
        logic            id_push;
        logic [XLEN-1:0] id_push_addr;
        logic            check;
        logic            exp_valid;
        logic            exp_branch;
        logic            exp_taken;
        logic [XLEN-1:0] exp_target;
    } vector_t;

    logic            clk;
    logic            rst;
    logic            fetch_valid;
    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] fetch_inst;
    logic            ex_valid;
    logic [XLEN-1:0] ex_pc;
    logic            ex_taken;
    logic [XLEN-1:0] ex_target;
    logic [XLEN-1:0] ex_inst;
    logic            ex_stall;
    logic            id_push;
    logic [XLEN-1:0] id_push_addr;
    logic            pred_valid;
    logic            pred_branch;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;

    vector_t vectors [$];
    logic    loaded = 1'b0;
    int      checks = 0;
    int      value_errors = 0;
    int      other_errors = 0;

    bpu_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid_i  (fetch_valid),
        .fetch_pc_i     (fetch_pc),
        .fetch_inst_i   (fetch_inst),
        .ex_valid_i     (ex_valid),
        .ex_pc_i        (ex_pc),
        .ex_taken_i     (ex_taken),
        .ex_target_i    (ex_target),
        .ex_inst_i      (ex_inst),
        .ex_stall_i     (ex_stall),
        .id_push_i      (id_push),
        .id_push_addr_i (id_push_addr),
        .pred_valid_o   (pred_valid),
        .pred_branch_o  (pred_branch),
        .pred_taken_o   (pred_taken),
        .pred_target_o  (pred_target)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic load_vectors;
        int              fd;
        int              code;
        string           line;
        logic [XLEN-1:0] col [16];
        vector_t         v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin  // skip column notes
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   col[0], col[1], col[2], col[3], col[4], col[5],
                                   col[6], col[7], col[8], col[9], col[10], col[11],
                                   col[12], col[13], col[14], col[15]);
                    if (code == 16) begin
                        v.fetch_valid  = col[0][0];
                        v.fetch_pc     = col[1];
                        v.fetch_inst   = col[2];
                        v.ex_valid     = col[3][0];
                        v.ex_pc        = col[4];
                        v.ex_taken     = col[5][0];
                        v.ex_target    = col[6];
                        v.ex_inst      = col[7];
                        v.ex_stall     = col[8][0];
                        v.id_push      = col[9][0];
                        v.id_push_addr = col[10];
                        v.check        = col[11][0];
                        v.exp_valid    = col[12][0];
                        v.exp_branch   = col[13][0];
                        v.exp_taken    = col[14][0];
                        v.exp_target   = col[15];
                        vectors.push_back(v);
                    end else if (code > 0) begin
                        $display("malformed stimulus line: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("stimulus file holds no vectors");
                other_errors++;
            end
        end
    endtask

    task automatic apply_vector(input vector_t v);
        fetch_valid  = v.fetch_valid;
        fetch_pc     = v.fetch_pc;
        fetch_inst   = v.fetch_inst;
        ex_valid     = v.ex_valid;
        ex_pc        = v.ex_pc;
        ex_taken     = v.ex_taken;
        ex_target    = v.ex_target;
        ex_inst      = v.ex_inst;
        ex_stall     = v.ex_stall;
        id_push      = v.id_push;
        id_push_addr = v.id_push_addr;
    endtask

    task automatic check_reset_outputs;
        checks++;
        if (pred_valid !== 1'b0) begin
            $display("Fail at %0t: pred_valid_o expected 0, got %b", $time, pred_valid);
            value_errors++;
        end
        if (pred_taken !== 1'b0) begin
            $display("Fail at %0t: pred_taken_o expected 0, got %b", $time, pred_taken);
            value_errors++;
        end
    endtask

    // target is only meaningful on a valid slot
    task automatic compare_outputs(input vector_t v);
        if (v.check) begin
            checks++;
            if (pred_valid !== v.exp_valid) begin
                $display("Fail at %0t: pred_valid_o expected %b, got %b",
                         $time, v.exp_valid, pred_valid);
                value_errors++;
            end
            if (pred_branch !== v.exp_branch) begin
                $display("Fail at %0t: pred_branch_o expected %b, got %b",
                         $time, v.exp_branch, pred_branch);
                value_errors++;
            end
            if (pred_taken !== v.exp_taken) begin
                $display("Fail at %0t: pred_taken_o expected %b, got %b",
                         $time, v.exp_taken, pred_taken);
                value_errors++;
            end
            if (v.exp_valid && (pred_target !== v.exp_target)) begin
                $display("Fail at %0t: pred_target_o expected %h, got %h",
                         $time, v.exp_target, pred_target);
                value_errors++;
            end
        end
    endtask

    // a fetch driven after edge k shows up after edge k+2
    task automatic run_vectors;
        vector_t pending [$];
        vector_t idle;
        vector_t due;
        idle = '0;
        for (int k = 0; k < vectors.size() + 2; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (pending.size() == 2) begin
                due = pending.pop_front();
                compare_outputs(due);
            end
            if (k < vectors.size()) begin
                apply_vector(vectors[k]);
                pending.push_back(vectors[k]);
            end else begin
                apply_vector(idle);  // drain the pipeline
                pending.push_back(idle);
            end
        end
    endtask

    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = (longint'(vectors.size()) + 20) * CLK_PERIOD * 2;
        #(limit_ns);
        $display("timeout: run still busy after %0d ns", limit_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        apply_vector('0);
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_reset_outputs();
        end
        rst = 1'b0;
        if (other_errors == 0) begin
            run_vectors();
        end
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/bpu_stimulus.txt
# fetch_valid fetch_pc fetch_inst ex_valid ex_pc ex_taken ex_target ex_inst ex_stall
# id_push id_push_addr check exp_valid exp_branch exp_taken exp_target, all hex
0 00000000 00000000 0 00000000 0 00000000 00000000 0 0 00000000 1 0 0 0 00000000
0 00000000 00000000 0 00000000 0 00000000 00000000 0 0 00000000 1 0 0 0 00000000
1 00000200 00100093 0 00000000 0 00000000 00000000 0 0 00000000 1 1 0 0 00000204
1 00000204 00100093 0 00000000 0 00000000 00000000 0 0 00000000 1 1 0 0 00000208
1 00001000 100000ef 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00001100
1 00001000 100000ef 1 00001000 1 00002000 100000ef 0 0 00000000 1 1 1 1 00001100
1 00001000 100000ef 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00002000
1 00001040 fe2088e3 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 0 00001044
1 00001040 fe2088e3 1 00001040 1 00001030 fe2088e3 0 0 00000000 1 1 1 0 00001044
0 00000000 00000000 1 00001040 1 00001030 fe2088e3 0 0 00000000 0 0 0 0 00000000
1 00001040 fe2088e3 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00001030
0 00000000 00000000 1 00001040 0 00001044 fe2088e3 0 0 00000000 0 0 0 0 00000000
1 00001040 fe2088e3 1 00001040 0 00001044 fe2088e3 0 0 00000000 1 1 1 1 00001030
1 00001040 fe2088e3 1 00001040 0 00001044 fe2088e3 0 0 00000000 1 1 1 0 00001044
1 00001040 fe2088e3 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 0 00001044
1 00001100 00008067 0 00000000 0 00000000 00000000 0 1 00003004 1 1 1 0 00001104
0 00000000 00000000 0 00000000 0 00000000 00000000 0 1 00004008 0 0 0 0 00000000
1 00001100 00008067 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00004008
1 00001100 00008067 1 00001100 1 00004008 00008067 0 0 00000000 1 1 1 1 00004008
1 00001100 00008067 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00003004
0 00000000 00000000 0 00000000 0 00000000 00000000 1 1 00005000 0 0 0 0 00000000
1 00001100 00008067 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00003004
0 00000000 00000000 1 00001100 1 00003004 00008067 1 0 00000000 0 0 0 0 00000000
1 00001100 00008067 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00003004
1 00001100 00008067 1 00001100 1 00003004 00008067 0 0 00000000 1 1 1 1 00003004
1 00001100 00008067 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 0 00001104
1 00000300 00100093 0 00000000 0 00000000 00000000 0 0 00000000 1 1 0 0 00000304
1 00001000 100000ef 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 1 00002000
1 00001040 fe2088e3 0 00000000 0 00000000 00000000 0 0 00000000 1 1 1 0 00001044
0 00000000 00000000 0 00000000 0 00000000 00000000 0 0 00000000 1 0 0 0 00000000

//--- bpu_top.f
logic/bpu_pkg.sv
logic/decode_stage.sv
logic/bimodal_table.sv
logic/target_buffer.sv
logic/return_stack.sv
logic/select_stage.sv
logic/bpu_top.sv
testbench/tb_bpu.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - logic/bpu_pkg.sv
  - logic/decode_stage.sv
  - logic/bimodal_table.sv
  - logic/target_buffer.sv
  - logic/return_stack.sv
  - logic/select_stage.sv
  - logic/bpu_top.sv
  - target: test
    files:
      - testbench/tb_bpu.sv
